//--- Bender.yml
package:
  name: vcache_profiler

sources:
  - design/vcache_prof_pkg.sv
  - design/vcache_op_event_decoder.sv
  - design/vcache_mem_event_decoder.sv
  - design/vcache_stat_counters.sv
  - design/vcache_stat_sampler.sv
  - design/vcache_profiler.sv
  - target: test
    files:
      - test/tb_vcache_profiler.sv

//--- design/vcache_mem_event_decoder.sv
/*
  memory side event decode, purely combinational
  a replacement is send_fill_addr with dma_done_i high, and is sorted
  by the valid and dirty bits of the chosen way
*/
`timescale 1ns/1ns
`default_nettype none

module vcache_mem_event_decoder #(
  parameter int  ways_p     = 8,
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1
) (
  input  wire logic                        rsp_v_i,
  input  wire logic                        rsp_yumi_i,
  input  wire logic                        miss_v_i,
  input  wire logic                        dma_pkt_v_i,
  input  wire logic                        dma_pkt_yumi_i,
  input  wire logic                        dma_write_not_read_i,
  input  wire logic                        dma_done_i,
  input  wire vcache_prof_pkg::dma_cmd_e   dma_cmd_i,
  input  wire logic [lg_ways_lp-1:0]       chosen_way_i,
  input  wire logic [ways_p-1:0]           valid_i,
  input  wire logic [ways_p-1:0]           dirty_i,
  output      vcache_prof_pkg::mem_event_s mem_event_o
);

  import vcache_prof_pkg::*;

  logic dma_accept;
  logic replacing;
  logic way_valid;
  logic way_dirty;

  assign dma_accept = dma_pkt_v_i & dma_pkt_yumi_i;
  assign replacing  = (dma_cmd_i == e_dma_send_fill_addr) & dma_done_i;

  assign way_valid = valid_i[chosen_way_i];
  assign way_dirty = dirty_i[chosen_way_i];

  always_comb begin
    mem_event_o = '0;

    mem_event_o.miss      = miss_v_i & ~rsp_v_i;   // miss handler busy
    mem_event_o.idle      = ~rsp_v_i & ~miss_v_i;
    mem_event_o.stall_rsp = rsp_v_i & ~rsp_yumi_i; // response not taken

    mem_event_o.dma_read  = dma_accept & ~dma_write_not_read_i;
    mem_event_o.dma_write = dma_accept & dma_write_not_read_i;

    mem_event_o.replace_invalid = replacing & ~way_valid;
    mem_event_o.replace_valid   = replacing & way_valid & ~way_dirty;
    mem_event_o.replace_dirty   = replacing & way_valid & way_dirty;
  end

endmodule

`default_nettype wire

//--- design/vcache_op_event_decoder.sv
/*
  request side event decode, purely combinational
  an access completes on rsp_v_i & rsp_yumi_i
  load subtypes need mask_op clear, store subtypes need mask_op set
  store subtypes are picked by mask popcount (8, 4, 2, 1 bytes)
*/
`timescale 1ns/1ns
`default_nettype none

module vcache_op_event_decoder #(
  parameter int mask_width_p = 4
) (
  input  wire logic                        rsp_v_i,
  input  wire logic                        rsp_yumi_i,
  input  wire logic                        miss_v_i,
  input  wire vcache_prof_pkg::decode_s    decode_i,
  input  wire logic [mask_width_p-1:0]     mask_i,
  output      vcache_prof_pkg::op_event_s  op_event_o
);

  import vcache_prof_pkg::*;

  localparam int pop_width_lp = $clog2(mask_width_p + 1);

  logic                    access;
  logic                    ld_plain;  // load without mask
  logic                    st_masked; // store with mask
  logic [pop_width_lp-1:0] mask_pop;

  assign access = rsp_v_i & rsp_yumi_i;

  // population count of the byte mask
  always_comb begin
    mask_pop = '0;
    for (int i = 0; i < mask_width_p; i++) begin
      mask_pop = mask_pop + pop_width_lp'(mask_i[i]);
    end
  end

  assign ld_plain  = access & decode_i.ld_op & ~decode_i.mask_op;
  assign st_masked = access & decode_i.st_op & decode_i.mask_op;

  always_comb begin
    op_event_o = '0;

    op_event_o.ld     = access & decode_i.ld_op;
    op_event_o.ld_ld  = ld_plain & (decode_i.data_size_op == 2'b11) & decode_i.sigext_op;
    op_event_o.ld_ldu = ld_plain & (decode_i.data_size_op == 2'b11) & ~decode_i.sigext_op;
    op_event_o.ld_lw  = ld_plain & (decode_i.data_size_op == 2'b10) & decode_i.sigext_op;
    op_event_o.ld_lwu = ld_plain & (decode_i.data_size_op == 2'b10) & ~decode_i.sigext_op;
    op_event_o.ld_lh  = ld_plain & (decode_i.data_size_op == 2'b01) & decode_i.sigext_op;
    op_event_o.ld_lhu = ld_plain & (decode_i.data_size_op == 2'b01) & ~decode_i.sigext_op;
    op_event_o.ld_lb  = ld_plain & (decode_i.data_size_op == 2'b00) & decode_i.sigext_op;
    op_event_o.ld_lbu = ld_plain & (decode_i.data_size_op == 2'b00) & ~decode_i.sigext_op;

    op_event_o.st    = access & decode_i.st_op;
    op_event_o.sm_sd = st_masked & (mask_pop == 8); // double, 64-bit words only
    op_event_o.sm_sw = st_masked & (mask_pop == 4);
    op_event_o.sm_sh = st_masked & (mask_pop == 2);
    op_event_o.sm_sb = st_masked & (mask_pop == 1);

    // tag and address maintenance
    op_event_o.tagst   = access & decode_i.tagst_op;
    op_event_o.tagfl   = access & decode_i.tagfl_op;
    op_event_o.taglv   = access & decode_i.taglv_op;
    op_event_o.tagla   = access & decode_i.tagla_op;
    op_event_o.afl     = access & decode_i.afl_op;
    op_event_o.aflinv  = access & decode_i.aflinv_op;
    op_event_o.ainv    = access & decode_i.ainv_op;
    op_event_o.alock   = access & decode_i.alock_op;
    op_event_o.aunlock = access & decode_i.aunlock_op;

    op_event_o.atomic  = access & decode_i.atomic_op;
    op_event_o.amoswap = op_event_o.atomic & (decode_i.amo_subop == e_amo_swap);
    op_event_o.amoor   = op_event_o.atomic & (decode_i.amo_subop == e_amo_or);
    op_event_o.amoadd  = op_event_o.atomic & (decode_i.amo_subop == e_amo_add);

    // access that went through the miss handler
    op_event_o.miss_ld  = access & decode_i.ld_op & miss_v_i;
    op_event_o.miss_st  = access & decode_i.st_op & miss_v_i;
    op_event_o.miss_amo = access & decode_i.atomic_op & miss_v_i;
  end

endmodule

`default_nettype wire

//--- design/vcache_prof_pkg.sv
/*
  shared types for the vector cache profiler
  count index i of a counts array belongs to bit i of its event struct,
  so the last field declared in an event struct is index 0
  counters and the global counter are stat_cnt_width bits and wrap
*/
`default_nettype none

package vcache_prof_pkg;

  localparam int stat_cnt_width = 32;

  // atomic sub-operations, only swap, or and add get their own counter
  typedef enum logic [3:0] {
    e_amo_swap = 4'd0,
    e_amo_add  = 4'd1,
    e_amo_xor  = 4'd2,
    e_amo_and  = 4'd3,
    e_amo_or   = 4'd4,
    e_amo_min  = 4'd5,
    e_amo_max  = 4'd6,
    e_amo_minu = 4'd7,
    e_amo_maxu = 4'd8
  } amo_subop_e;

  // miss handler DMA commands
  typedef enum logic [2:0] {
    e_dma_nop             = 3'd0,
    e_dma_send_fill_addr  = 3'd1,
    e_dma_send_evict_addr = 3'd2,
    e_dma_get_fill_data   = 3'd3,
    e_dma_send_evict_data = 3'd4
  } dma_cmd_e;

  typedef struct packed {
    logic       ld_op;
    logic       st_op;
    logic       mask_op;
    logic       sigext_op;
    logic [1:0] data_size_op; // 00 byte, 01 half, 10 word, 11 double
    logic       tagst_op;
    logic       tagfl_op;
    logic       taglv_op;
    logic       tagla_op;
    logic       afl_op;
    logic       aflinv_op;
    logic       ainv_op;
    logic       alock_op;
    logic       aunlock_op;
    logic       atomic_op;
    amo_subop_e amo_subop;
  } decode_s;

  typedef struct packed {
    logic ld, ld_ld, ld_ldu, ld_lw, ld_lwu, ld_lh, ld_lhu, ld_lb, ld_lbu;
    logic st, sm_sd, sm_sw, sm_sh, sm_sb;
    logic tagst, tagfl, taglv, tagla;
    logic afl, aflinv, ainv, alock, aunlock;
    logic atomic, amoswap, amoor, amoadd;
    logic miss_ld, miss_st, miss_amo;
  } op_event_s;

  typedef struct packed {
    logic miss;
    logic idle;
    logic stall_rsp;
    logic dma_read;
    logic dma_write;
    logic replace_invalid;
    logic replace_valid;
    logic replace_dirty;
  } mem_event_s;

  typedef logic [$bits(op_event_s)-1:0][stat_cnt_width-1:0]  op_counts_t;
  typedef logic [$bits(mem_event_s)-1:0][stat_cnt_width-1:0] mem_counts_t;

  // count indices used by the periodic summary
  localparam int op_ld_idx         = 29;
  localparam int op_st_idx         = 20;
  localparam int op_atomic_idx     = 6;
  localparam int mem_miss_idx      = 7;
  localparam int mem_idle_idx      = 6;
  localparam int mem_stall_rsp_idx = 5;

  typedef struct packed {
    logic [31:0]               tag;
    logic [stat_cnt_width-1:0] global_ctr;
    op_counts_t                op_counts;
    mem_counts_t               mem_counts;
  } stat_snap_s;

  typedef struct packed {
    logic [stat_cnt_width-1:0] global_ctr;
    logic [stat_cnt_width-1:0] ld_count;
    logic [stat_cnt_width-1:0] st_count;
    logic [stat_cnt_width-1:0] atomic_count;
    logic [stat_cnt_width-1:0] miss_count;
    logic [stat_cnt_width-1:0] stall_rsp_count;
    logic [stat_cnt_width-1:0] idle_count;
  } periodic_s;

endpackage

`default_nettype wire

//--- design/vcache_profiler.sv
/*
  performance counters for a non-blocking vector cache
  pure observer, never stalls the cache
  word_width_p must be a multiple of 8, print tag is 32 bits
  one cycle from print strobe to snap_v_o
*/
`timescale 1ns/1ns
`default_nettype none

module vcache_profiler #(
  parameter int  word_width_p  = 32,
  parameter int  ways_p        = 8,
  parameter int  period_p      = 250,
  localparam int mask_width_lp = word_width_p / 8,
  localparam int lg_ways_lp    = (ways_p > 1) ? $clog2(ways_p) : 1
) (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,

  // response side
  input  wire logic                        rsp_v_i,
  input  wire logic                        rsp_yumi_i,
  input  wire logic                        miss_v_i,
  input  wire vcache_prof_pkg::decode_s    decode_i,
  input  wire logic [mask_width_lp-1:0]    mask_i,

  // miss handler and DMA
  input  wire logic                        dma_pkt_v_i,
  input  wire logic                        dma_pkt_yumi_i,
  input  wire logic                        dma_write_not_read_i,
  input  wire logic                        dma_done_i,
  input  wire vcache_prof_pkg::dma_cmd_e   dma_cmd_i,
  input  wire logic [lg_ways_lp-1:0]       chosen_way_i,
  input  wire logic [ways_p-1:0]           valid_i,
  input  wire logic [ways_p-1:0]           dirty_i,

  // sampling
  input  wire logic                        print_stat_v_i,
  input  wire logic [31:0]                 print_stat_tag_i,
  input  wire logic [31:0]                 global_ctr_i,
  output      logic                        snap_v_o,
  output      vcache_prof_pkg::stat_snap_s snap_o,
  output      logic                        periodic_v_o,
  output      vcache_prof_pkg::periodic_s  periodic_o
);

  import vcache_prof_pkg::*;

  op_event_s   op_event;
  mem_event_s  mem_event;
  op_counts_t  op_counts;
  mem_counts_t mem_counts;

  vcache_op_event_decoder #(
    .mask_width_p(mask_width_lp)
  ) op_dec_i (
    .rsp_v_i   (rsp_v_i),
    .rsp_yumi_i(rsp_yumi_i),
    .miss_v_i  (miss_v_i),
    .decode_i  (decode_i),
    .mask_i    (mask_i),
    .op_event_o(op_event)
  );

  vcache_mem_event_decoder #(
    .ways_p(ways_p)
  ) mem_dec_i (
    .rsp_v_i             (rsp_v_i),
    .rsp_yumi_i          (rsp_yumi_i),
    .miss_v_i            (miss_v_i),
    .dma_pkt_v_i         (dma_pkt_v_i),
    .dma_pkt_yumi_i      (dma_pkt_yumi_i),
    .dma_write_not_read_i(dma_write_not_read_i),
    .dma_done_i          (dma_done_i),
    .dma_cmd_i           (dma_cmd_i),
    .chosen_way_i        (chosen_way_i),
    .valid_i             (valid_i),
    .dirty_i             (dirty_i),
    .mem_event_o         (mem_event)
  );

  vcache_stat_counters #(
    .event_t(op_event_s)
  ) op_cnt_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .event_i (op_event),
    .counts_o(op_counts)
  );

  vcache_stat_counters #(
    .event_t(mem_event_s)
  ) mem_cnt_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .event_i (mem_event),
    .counts_o(mem_counts)
  );

  vcache_stat_sampler #(
    .period_p(period_p)
  ) sampler_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .print_stat_v_i  (print_stat_v_i),
    .print_stat_tag_i(print_stat_tag_i),
    .global_ctr_i    (global_ctr_i),
    .op_counts_i     (op_counts),
    .mem_counts_i    (mem_counts),
    .snap_v_o        (snap_v_o),
    .snap_o          (snap_o),
    .periodic_v_o    (periodic_v_o),
    .periodic_o      (periodic_o)
  );

endmodule

`default_nettype wire

//--- design/vcache_stat_counters.sv
/*
  one wrapping counter per bit of event_t
  an event in cycle N is visible in counts_o from cycle N+1
  counts_o[i] belongs to bit i of the event vector
*/
`timescale 1ns/1ns
`default_nettype none

module vcache_stat_counters #(
  parameter type event_t = logic
) (
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire event_t event_i,
  output      logic [$bits(event_t)-1:0][vcache_prof_pkg::stat_cnt_width-1:0] counts_o
);

  import vcache_prof_pkg::*;

  localparam int num_events_lp = $bits(event_t);

  logic [num_events_lp-1:0]                     event_bits;
  logic [num_events_lp-1:0][stat_cnt_width-1:0] counts_r;

  assign event_bits = event_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      counts_r <= '0;
    end else begin
      for (int i = 0; i < num_events_lp; i++) begin
        if (event_bits[i]) begin
          counts_r[i] <= counts_r[i] + stat_cnt_width'(1); // wraps at 2**32
        end
      end
    end
  end

  assign counts_o = counts_r;

endmodule

`default_nettype wire

//--- design/vcache_stat_sampler.sv
/*
  snapshot on print_stat_v_i: counts as they stand in the strobe cycle,
  so that cycle's own events are not included
  snap_v_o pulses one cycle after the strobe, data held until next strobe
  periodic sample only once a kernel-start tag (top bits 10) was seen
  period_p must be nonzero
*/
`timescale 1ns/1ns
`default_nettype none

module vcache_stat_sampler #(
  parameter int period_p = 250
) (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         print_stat_v_i,
  input  wire logic [31:0]                  print_stat_tag_i,
  input  wire logic [31:0]                  global_ctr_i,
  input  wire vcache_prof_pkg::op_counts_t  op_counts_i,
  input  wire vcache_prof_pkg::mem_counts_t mem_counts_i,
  output      logic                         snap_v_o,
  output      vcache_prof_pkg::stat_snap_s  snap_o,
  output      logic                         periodic_v_o,
  output      vcache_prof_pkg::periodic_s   periodic_o
);

  import vcache_prof_pkg::*;

  logic       snap_v_r;
  stat_snap_s snap_r;
  logic       periodic_v_r;
  periodic_s  periodic_r;
  logic       kernel_start_r;
  logic       kernel_tag;
  logic       period_hit;

  assign kernel_tag = print_stat_tag_i[31:30] == 2'b10;
  assign period_hit = kernel_start_r & ((global_ctr_i % period_p) == 0);

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_v_r       <= 1'b0;
      periodic_v_r   <= 1'b0;
      kernel_start_r <= 1'b0;
    end else begin
      snap_v_r     <= print_stat_v_i;
      periodic_v_r <= period_hit;
      if (print_stat_v_i && kernel_tag) begin
        kernel_start_r <= 1'b1; // sticky until reset
      end
    end
  end

  // snapshot payload
  always_ff @(posedge clk_i) begin
    if (print_stat_v_i) begin
      snap_r.tag        <= print_stat_tag_i;
      snap_r.global_ctr <= global_ctr_i;
      snap_r.op_counts  <= op_counts_i;
      snap_r.mem_counts <= mem_counts_i;
    end
  end

  // periodic summary payload
  always_ff @(posedge clk_i) begin
    if (period_hit) begin
      periodic_r.global_ctr      <= global_ctr_i;
      periodic_r.ld_count        <= op_counts_i[op_ld_idx];
      periodic_r.st_count        <= op_counts_i[op_st_idx];
      periodic_r.atomic_count    <= op_counts_i[op_atomic_idx];
      periodic_r.miss_count      <= mem_counts_i[mem_miss_idx];
      periodic_r.stall_rsp_count <= mem_counts_i[mem_stall_rsp_idx];
      periodic_r.idle_count      <= mem_counts_i[mem_idle_idx];
    end
  end

  assign snap_v_o     = snap_v_r;
  assign snap_o       = snap_r;
  assign periodic_v_o = periodic_v_r;
  assign periodic_o   = periodic_r;

endmodule

`default_nettype wire

//--- tb.f
design/vcache_prof_pkg.sv
design/vcache_op_event_decoder.sv
design/vcache_mem_event_decoder.sv
design/vcache_stat_counters.sv
design/vcache_stat_sampler.sv
design/vcache_profiler.sv
test/tb_vcache_profiler.sv

//--- test/tb_vcache_profiler.sv
/*
  testbench for vcache_profiler with word_width_p 32, ways_p 4, period_p 8
  directed stimulus and expected counts come from test/vcache_profiler_vectors.txt,
  so the simulator must run from the project root
  400 random cycles follow, every cycle is checked against a cycle model
*/
`timescale 1ns/1ns
`default_nettype none

module tb_vcache_profiler;

  import vcache_prof_pkg::*;

  localparam int period_lp     = 8;
  localparam int random_lp     = 400;
  localparam int ld_idx_lp     = 29; // ld is the first of 30 op events
  localparam int st_idx_lp     = 20;
  localparam int atomic_idx_lp = 6;
  localparam int miss_idx_lp   = 7;  // mem events: miss first of 8
  localparam int idle_idx_lp   = 6;
  localparam int stall_idx_lp  = 5;

  // one cycle of DUT inputs
  typedef struct packed {
    logic        rsp_v;
    logic        rsp_yumi;
    logic        miss_v;
    decode_s     decode;
    logic [3:0]  mask;
    logic        dma_v;
    logic        dma_yumi;
    logic        dma_wnr;
    logic        dma_done;
    dma_cmd_e    dma_cmd;
    logic [1:0]  way;
    logic [3:0]  valid;
    logic [3:0]  dirty;
    logic        print_v;
    logic [31:0] tag;
  } stim_s;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] gctr;
  stim_s       cur;
  logic        snap_v;
  stat_snap_s  snap;
  logic        periodic_v;
  periodic_s   periodic;

  stim_s drive_q[$];
  string chk_name_q[$];
  string chk_bank_q[$];
  int    chk_idx_q[$];
  int    chk_val_q[$];
  int    chk_at_q[$];  // index of the drive line that follows the check
  int    chk_done;
  int    chk_armed;

  // model state
  op_counts_t  m_op;
  mem_counts_t m_mem;
  logic        m_kernel;
  logic        exp_snap_v;
  stat_snap_s  exp_snap;
  logic        have_snap;
  logic        exp_per_v;
  periodic_s   exp_per;

  int     snap_err    = 0;
  int     per_err     = 0;
  int     valid_err   = 0;
  int     count_err   = 0;
  int     other_err   = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;
  integer seed;
  int     step;

  vcache_profiler #(
    .word_width_p(32),
    .ways_p      (4),
    .period_p    (period_lp)
  ) dut_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .rsp_v_i             (cur.rsp_v),
    .rsp_yumi_i          (cur.rsp_yumi),
    .miss_v_i            (cur.miss_v),
    .decode_i            (cur.decode),
    .mask_i              (cur.mask),
    .dma_pkt_v_i         (cur.dma_v),
    .dma_pkt_yumi_i      (cur.dma_yumi),
    .dma_write_not_read_i(cur.dma_wnr),
    .dma_done_i          (cur.dma_done),
    .dma_cmd_i           (cur.dma_cmd),
    .chosen_way_i        (cur.way),
    .valid_i             (cur.valid),
    .dirty_i             (cur.dirty),
    .print_stat_v_i      (cur.print_v),
    .print_stat_tag_i    (cur.tag),
    .global_ctr_i        (gctr),
    .snap_v_o            (snap_v),
    .snap_o              (snap),
    .periodic_v_o        (periodic_v),
    .periodic_o          (periodic)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // returns 0 only when the vector file cannot be opened
  function automatic bit read_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       bank;
    int          idx;
    int          val;
    logic [31:0] f [0:14];
    stim_s       s;
    fd = $fopen("test/vcache_profiler_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/vcache_profiler_vectors.txt");
      return 1'b0;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line[0] == "D") begin
        n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (n != 15) begin
          $display("malformed drive line in vector file: %s", line);
          other_err++;
        end else begin
          s.rsp_v    = f[0][0];
          s.rsp_yumi = f[1][0];
          s.miss_v   = f[2][0];
          s.decode   = f[3][19:0];
          s.mask     = f[4][3:0];
          s.dma_v    = f[5][0];
          s.dma_yumi = f[6][0];
          s.dma_wnr  = f[7][0];
          s.dma_done = f[8][0];
          s.dma_cmd  = dma_cmd_e'(f[9][2:0]);
          s.way      = f[10][1:0];
          s.valid    = f[11][3:0];
          s.dirty    = f[12][3:0];
          s.print_v  = f[13][0];
          s.tag      = f[14];
          drive_q.push_back(s);
        end
      end else if (n > 0 && line[0] == "C") begin
        n = $sscanf(line, "C %s %s %d %d", name, bank, idx, val);
        if (n != 4 || !((bank == "op" && idx >= 0 && idx < $bits(op_event_s)) ||
                        (bank == "mem" && idx >= 0 && idx < $bits(mem_event_s)))) begin
          $display("malformed check line in vector file: %s", line);
          other_err++;
        end else begin
          chk_name_q.push_back(name);
          chk_bank_q.push_back(bank);
          chk_idx_q.push_back(idx);
          chk_val_q.push_back(val);
          chk_at_q.push_back(drive_q.size());
        end
      end else if (n > 0 && line[0] != "#" && line[0] != "\n") begin
        $display("unrecognized line in vector file: %s", line);
        other_err++;
      end
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  function automatic stim_s random_stim();
    stim_s       s;
    logic [31:0] r;
    logic [31:0] d;
    r = $random(seed);
    d = $random(seed);
    s.rsp_v    = r[0];
    s.rsp_yumi = r[1];
    s.miss_v   = r[2];
    s.mask     = r[6:3];
    s.dma_v    = r[7];
    s.dma_yumi = r[8];
    s.dma_wnr  = r[9];
    s.dma_done = r[10];
    s.dma_cmd  = dma_cmd_e'(3'(r[13:11] % 3'd5));
    s.way      = r[15:14];
    s.valid    = r[19:16];
    s.dirty    = r[23:20];
    s.print_v  = (r[27:24] == 4'd0); // about one strobe in 16 cycles
    s.tag      = $random(seed);
    s.decode   = d[19:0];
    s.decode.amo_subop = amo_subop_e'(4'(d[23:20] % 4'd9));
    return s;
  endfunction

  function automatic stim_s next_stim(input int k);
    if (k < drive_q.size()) begin
      return drive_q[k];
    end else if (k < drive_q.size() + random_lp) begin
      return random_stim();
    end
    return '0; // drain cycles
  endfunction

  function automatic op_event_s model_op_events(input stim_s s);
    op_event_s e;
    logic      acc;
    logic      plain_ld;
    logic      mask_st;
    int        pop;
    e        = '0;
    acc      = s.rsp_v & s.rsp_yumi;
    plain_ld = acc & s.decode.ld_op & ~s.decode.mask_op;
    mask_st  = acc & s.decode.st_op & s.decode.mask_op;
    pop      = 0;
    for (int i = 0; i < 4; i++) begin
      pop = pop + int'(s.mask[i]);
    end
    e.ld = acc & s.decode.ld_op;
    case ({s.decode.data_size_op, s.decode.sigext_op})
      3'b111: e.ld_ld  = plain_ld;
      3'b110: e.ld_ldu = plain_ld;
      3'b101: e.ld_lw  = plain_ld;
      3'b100: e.ld_lwu = plain_ld;
      3'b011: e.ld_lh  = plain_ld;
      3'b010: e.ld_lhu = plain_ld;
      3'b001: e.ld_lb  = plain_ld;
      default: e.ld_lbu = plain_ld;
    endcase
    e.st = acc & s.decode.st_op;
    case (pop)
      8: e.sm_sd = mask_st;
      4: e.sm_sw = mask_st;
      2: e.sm_sh = mask_st;
      1: e.sm_sb = mask_st;
      default: ;
    endcase
    e.tagst   = acc & s.decode.tagst_op;
    e.tagfl   = acc & s.decode.tagfl_op;
    e.taglv   = acc & s.decode.taglv_op;
    e.tagla   = acc & s.decode.tagla_op;
    e.afl     = acc & s.decode.afl_op;
    e.aflinv  = acc & s.decode.aflinv_op;
    e.ainv    = acc & s.decode.ainv_op;
    e.alock   = acc & s.decode.alock_op;
    e.aunlock = acc & s.decode.aunlock_op;
    e.atomic  = acc & s.decode.atomic_op;
    case (s.decode.amo_subop)
      e_amo_swap: e.amoswap = e.atomic;
      e_amo_or:   e.amoor   = e.atomic;
      e_amo_add:  e.amoadd  = e.atomic;
      default: ;
    endcase
    e.miss_ld  = e.ld & s.miss_v;
    e.miss_st  = e.st & s.miss_v;
    e.miss_amo = e.atomic & s.miss_v;
    return e;
  endfunction

  function automatic mem_event_s model_mem_events(input stim_s s);
    mem_event_s e;
    e           = '0;
    e.miss      = s.miss_v & ~s.rsp_v;
    e.idle      = ~s.rsp_v & ~s.miss_v;
    e.stall_rsp = s.rsp_v & ~s.rsp_yumi;
    e.dma_read  = s.dma_v & s.dma_yumi & ~s.dma_wnr;
    e.dma_write = s.dma_v & s.dma_yumi & s.dma_wnr;
    if (s.dma_done && s.dma_cmd == e_dma_send_fill_addr) begin
      if (!s.valid[s.way]) begin
        e.replace_invalid = 1'b1;
      end else if (s.dirty[s.way]) begin
        e.replace_dirty = 1'b1;
      end else begin
        e.replace_valid = 1'b1;
      end
    end
    return e;
  endfunction

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b actual %b", name, exp, act);
      valid_err++;
    end
  endtask

  task automatic check_count(input string name, input logic [stat_cnt_width-1:0] exp,
                             input logic [stat_cnt_width-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0d actual %0d", name, exp, act);
      count_err++;
    end
  endtask

  task automatic check_snap(input string name, input stat_snap_s exp, input stat_snap_s act);
    if (act.tag !== exp.tag) begin
      $display("FAILED %s: tag expected %h actual %h", name, exp.tag, act.tag);
      snap_err++;
    end
    if (act.global_ctr !== exp.global_ctr) begin
      $display("FAILED %s: global counter expected %0d actual %0d",
               name, exp.global_ctr, act.global_ctr);
      snap_err++;
    end
    for (int i = 0; i < $bits(op_event_s); i++) begin
      if (act.op_counts[i] !== exp.op_counts[i]) begin
        $display("FAILED %s: op count %0d expected %0d actual %0d",
                 name, i, exp.op_counts[i], act.op_counts[i]);
        snap_err++;
      end
    end
    for (int i = 0; i < $bits(mem_event_s); i++) begin
      if (act.mem_counts[i] !== exp.mem_counts[i]) begin
        $display("FAILED %s: mem count %0d expected %0d actual %0d",
                 name, i, exp.mem_counts[i], act.mem_counts[i]);
        snap_err++;
      end
    end
  endtask

  task automatic check_periodic(input string name, input periodic_s exp, input periodic_s act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h actual %h", name, exp, act);
      per_err++;
    end
  endtask

  // directed counts armed by the last strobe
  task automatic apply_directed();
    logic [stat_cnt_width-1:0] act;
    while (chk_done < chk_armed) begin
      if (chk_bank_q[chk_done] == "op") begin
        act = snap.op_counts[chk_idx_q[chk_done]];
      end else begin
        act = snap.mem_counts[chk_idx_q[chk_done]];
      end
      check_count(chk_name_q[chk_done], chk_val_q[chk_done], act);
      chk_done++;
    end
  endtask

  // outputs at the negedge reflect the previous cycle's inputs
  task automatic check_outputs();
    check_valid("snapshot valid", exp_snap_v, snap_v);
    check_valid("periodic valid", exp_per_v, periodic_v);
    if (exp_snap_v) begin
      have_snap = 1'b1;
      check_snap("snapshot", exp_snap, snap);
      apply_directed();
    end else if (have_snap) begin
      check_snap("snapshot held", exp_snap, snap);
    end
    if (exp_per_v) begin
      check_periodic("periodic sample", exp_per, periodic);
    end
  endtask

  task automatic model_cycle(input int k);
    logic [$bits(op_event_s)-1:0]  ob;
    logic [$bits(mem_event_s)-1:0] mb;
    ob = model_op_events(cur);
    mb = model_mem_events(cur);
    exp_snap_v = cur.print_v;
    if (cur.print_v) begin
      exp_snap.tag        = cur.tag;
      exp_snap.global_ctr = gctr;
      exp_snap.op_counts  = m_op;  // before this cycle's events
      exp_snap.mem_counts = m_mem;
      while (chk_armed < chk_at_q.size() && chk_at_q[chk_armed] <= k) begin
        chk_armed++;
      end
    end
    exp_per_v = m_kernel && (gctr % period_lp == 0);
    if (exp_per_v) begin
      exp_per.global_ctr      = gctr;
      exp_per.ld_count        = m_op[ld_idx_lp];
      exp_per.st_count        = m_op[st_idx_lp];
      exp_per.atomic_count    = m_op[atomic_idx_lp];
      exp_per.miss_count      = m_mem[miss_idx_lp];
      exp_per.stall_rsp_count = m_mem[stall_idx_lp];
      exp_per.idle_count      = m_mem[idle_idx_lp];
    end
    if (cur.print_v && cur.tag[31:30] == 2'b10) begin
      m_kernel = 1'b1;
    end
    for (int i = 0; i < $bits(op_event_s); i++) begin
      if (ob[i]) begin
        m_op[i] = m_op[i] + 1'b1;
      end
    end
    for (int i = 0; i < $bits(mem_event_s); i++) begin
      if (mb[i]) begin
        m_mem[i] = m_mem[i] + 1'b1;
      end
    end
  endtask

  initial begin
    seed       = 32'h8a9869a6;
    reset_i    = 1'b1;
    gctr       = '0;
    cur        = '0;
    m_op       = '0;
    m_mem      = '0;
    m_kernel   = 1'b0;
    exp_snap_v = 1'b0;
    exp_snap   = '0;
    have_snap  = 1'b0;
    exp_per_v  = 1'b0;
    exp_per    = '0;
    chk_done   = 0;
    chk_armed  = 0;
    if (!read_vectors()) begin
      $display("test failed");
      $finish;
    end else begin
      cycle_limit = drive_q.size() + random_lp + 50;
      repeat (4) @(posedge clk_i); // reset seen on 5 edges
      for (step = 0; step < drive_q.size() + random_lp + 2; step++) begin
        @(posedge clk_i);
        reset_i <= 1'b0;
        gctr    <= 32'(step);
        cur     <= next_stim(step);
        @(negedge clk_i);
        check_outputs();
        model_cycle(step);
      end
      $display("errors: snapshot %0d, periodic %0d, valid %0d, directed %0d, other %0d",
               snap_err, per_err, valid_err, count_err, other_err);
      if (snap_err + per_err + valid_err + count_err + other_err == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- test/vcache_profiler_vectors.txt
# D rsp_v rsp_yumi miss_v decode mask dma_v dma_yumi write_not_read done cmd way valid dirty print_v tag (hex)
# C test_name op|mem count_index expected (decimal), checked at the snapshot of the next strobe
C reset_zero_idle mem 6 0
D 0 0 0 00000 0 0 0 0 0 0 0 0 0 1 00000011
D 1 1 0 98000 0 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 80000 0 0 0 0 0 0 0 0 0 0 00000000
D 1 0 0 98000 0 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 60000 f 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 60000 3 0 0 0 0 0 0 0 0 0 00000000
D 1 1 1 60000 1 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 00010 0 0 0 0 0 0 0 0 0 0 00000000
D 1 1 1 00014 0 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 00012 0 0 0 0 0 0 0 0 0 0 00000000
D 1 1 0 02000 0 0 0 0 0 0 0 0 0 0 00000000
D 0 0 1 00000 0 0 0 0 0 0 0 0 0 0 00000000
D 0 0 0 00000 0 1 1 0 0 0 0 0 0 0 00000000
D 0 0 0 00000 0 1 1 1 0 0 0 0 0 0 00000000
D 0 0 0 00000 0 0 0 0 1 1 2 b 0 0 00000000
D 0 0 0 00000 0 0 0 0 1 1 1 b 0 0 00000000
D 0 0 0 00000 0 0 0 0 1 1 3 b 8 0 00000000
C loads_excl_own op 29 2
C load_lw op 26 1
C load_lbu op 21 1
C store_sw op 18 1
C store_sb op 16 1
C miss_store op 1 1
C amo_or op 4 1
C amo_add_none op 3 0
C atomics op 6 3
C stall_rsp mem 5 1
C idle mem 6 6
C replace_dirty mem 0 1
D 1 1 0 98000 0 0 0 0 0 0 0 0 0 1 80000002
D 0 0 0 00000 0 0 0 0 0 0 0 0 0 0 00000000
D 0 0 0 00000 0 0 0 0 0 0 0 0 0 0 00000000
D 0 0 0 00000 0 0 0 0 0 0 0 0 0 0 00000000
C loads_late op 29 3
C load_lw_late op 26 2
C idle_late mem 6 9
D 0 0 0 00000 0 0 0 0 0 0 0 0 0 1 00000003
